// File: Bender.yml
package:
  name: am_lock

sources:
  - verilog/am_pkg.sv
  - verilog/am_marker_match.sv
  - verilog/am_period_timer.sv
  - verilog/am_lock_fsm.sv
  - verilog/am_lane_output.sv
  - verilog/am_lock_top.sv
  - target: test
    files:
      - tests/am_lock_sva.sv
      - tests/tb_am_lock.sv

// File: sim.f
verilog/am_pkg.sv
verilog/am_marker_match.sv
verilog/am_period_timer.sv
verilog/am_lock_fsm.sv
verilog/am_lane_output.sv
verilog/am_lock_top.sv
tests/am_lock_sva.sv
tests/tb_am_lock.sv

// File: tests/am_lock_sva.sv
module am_lock_sva
    import am_pkg::*;
(
    input logic                        i_clock,
    input logic                        i_reset,
    input logic                        i_out_valid,
    input logic                        i_am_lock,
    input logic                        i_resync,
    input logic                        i_start_of_lane,
    input logic [NB_ERROR_COUNTER-1:0] i_error_counter
);

    timeunit 1ns;
    timeprecision 100ps;

    int fail_count = 0;   // failed assertions so far

    // lock is already gone in the resync cycle
    resync_pulse_a: assert property (
        @(posedge i_clock) disable iff (i_reset)
        i_resync |-> !i_am_lock ##1 !i_resync
    )
    else
    begin
        $error("o_resync longer than one cycle or seen with lock high");
        fail_count++;
    end

    sol_locked_a: assert property (
        @(posedge i_clock) disable iff (i_reset)
        i_start_of_lane |-> i_am_lock && i_out_valid
    )
    else
    begin
        $error("o_start_of_lane without lock or without a block");
        fail_count++;
    end

    // saturating counter never wraps
    err_monotonic_a: assert property (
        @(posedge i_clock) disable iff (i_reset)
        i_error_counter >= $past(i_error_counter)
    )
    else
    begin
        $error("o_error_counter went down");
        fail_count++;
    end

endmodule

bind am_lock_top am_lock_sva am_lock_sva_i (
    .i_clock         (i_clock),
    .i_reset         (i_reset),
    .i_out_valid     (o_valid),
    .i_am_lock       (o_am_lock),
    .i_resync        (o_resync),
    .i_start_of_lane (o_start_of_lane),
    .i_error_counter (o_error_counter)
);

// File: tests/tb_am_lock.sv
module tb_am_lock
    import am_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    // one expected output block as the model sees it
    typedef struct packed {
        logic [NB_CODED_BLOCK-1:0]   data;
        logic                        lock;
        logic [NB_LANE_ID-1:0]       lane;
        logic                        resync;
        logic                        sol;
        logic [NB_ERROR_COUNTER-1:0] err;
        int                          due;   // cycle in which o_valid brings it
    } expect_t;

    logic                        tb_clock;
    logic                        tb_reset;
    logic                        enable;
    logic                        valid;
    logic                        block_lock;
    logic [NB_CODED_BLOCK-1:0]   data_in;
    logic [NB_VAL_AM-1:0]        valid_thr;
    logic [NB_INV_AM-1:0]        invalid_thr;
    logic                        out_valid;
    logic [NB_CODED_BLOCK-1:0]   out_data;
    logic [NB_LANE_ID-1:0]       lane_id;
    logic                        am_lock;
    logic                        resync;
    logic                        start_of_lane;
    logic [NB_ERROR_COUNTER-1:0] error_counter;

    int      seed;
    int      errors;
    int      timeouts;
    int      lock_seen;
    int      resync_seen;
    int      sol_seen;
    int      cycle_count;
    expect_t exp_q[$];
    expect_t head;

    // reference model state
    am_lock_state_t              m_state;
    logic [NB_LANE_ID-1:0]       m_lane;
    int                          m_good;
    int                          m_bad;
    int                          m_since;   // accepted blocks since last slot
    logic [NB_ERROR_COUNTER-1:0] m_err;
    int                          vthr;
    int                          ithr;

    am_lock_top am_lock_top_i (
        .i_clock          (tb_clock),
        .i_reset          (tb_reset),
        .i_enable         (enable),
        .i_valid          (valid),
        .i_block_lock     (block_lock),
        .i_data           (data_in),
        .i_valid_am_thr   (valid_thr),
        .i_invalid_am_thr (invalid_thr),
        .o_valid          (out_valid),
        .o_data           (out_data),
        .o_lane_id        (lane_id),
        .o_am_lock        (am_lock),
        .o_resync         (resync),
        .o_start_of_lane  (start_of_lane),
        .o_error_counter  (error_counter)
    );

    always #2 tb_clock = ~tb_clock;

    // rising edges since time zero
    always @(posedge tb_clock)
        cycle_count++;

    task automatic check_value(input string what, input logic [127:0] got,
                               input logic [127:0] exp);
        if (got !== exp)
        begin
            errors++;
            $display("error at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    function automatic int rand_range(input int lo, input int hi);
        logic [31:0] r;
        r = $random(seed);
        return lo + int'(r % 32'(hi - lo + 1));
    endfunction

    function automatic logic [NB_CODED_BLOCK-1:0] make_marker(input int lane);
        logic [23:0] m;
        logic [7:0]  bip3;
        logic [7:0]  bip7;
        m    = AM_TABLE[lane];
        bip3 = 8'($random(seed));   // parity bytes are don't care here
        bip7 = 8'($random(seed));
        return {AM_SYNC_HEADER, m, bip3, ~m, bip7};
    endfunction

    // mostly data blocks and sometimes near misses of a marker
    function automatic logic [NB_CODED_BLOCK-1:0] random_block();
        logic [NB_CODED_BLOCK-1:0] blk;
        int                        kind;
        int                        bitpos;
        kind = rand_range(0, 15);
        blk  = {2'b01, 32'($random(seed)), 32'($random(seed))};
        if (kind == 0)
            blk[65:64] = AM_SYNC_HEADER;
        else if (kind == 1)
        begin
            blk    = make_marker(rand_range(0, N_ALIGNER - 1));
            bitpos = rand_range(8, 31);
            blk[bitpos] = ~blk[bitpos];   // broken complement
        end
        else if (kind == 2)
        begin
            blk        = make_marker(rand_range(0, N_ALIGNER - 1));
            blk[65:64] = 2'b01;   // wrong header
        end
        return blk;
    endfunction

    // lane by the marker rule or -1 for a block that is no marker
    function automatic int marker_lane(input logic [NB_CODED_BLOCK-1:0] blk);
        int lane;
        lane = -1;
        for (int k = 0; k < N_ALIGNER; k++)
        begin
            if (blk[65:64] == AM_SYNC_HEADER && blk[63:40] == AM_TABLE[k]
                && blk[31:8] == ~AM_TABLE[k])
                lane = k;
        end
        return lane;
    endfunction

    function automatic void model_accept(input logic [NB_CODED_BLOCK-1:0] blk);
        int      lane;
        logic    slot;
        logic    hit;
        expect_t e;
        lane   = marker_lane(blk);
        e      = '0;
        e.data = blk;
        e.due  = cycle_count + 2;
        slot   = 1'b0;
        hit    = (lane >= 0) && (lane == int'(m_lane));
        if (m_state != AM_UNLOCKED)
        begin
            m_since++;
            if (m_since == N_BLOCKS)
            begin
                slot    = 1'b1;
                m_since = 0;
            end
        end
        if (!block_lock)
            m_state = AM_UNLOCKED;
        else
        begin
            case (m_state)
                AM_UNLOCKED:
                    if (lane >= 0)
                    begin
                        m_lane  = NB_LANE_ID'(lane);
                        m_good  = 1;
                        m_bad   = 0;
                        m_since = 0;
                        m_state = (m_good >= vthr) ? AM_LOCKED : AM_ACQUIRE;
                    end
                AM_ACQUIRE:
                    if (slot && hit)
                    begin
                        m_good++;
                        if (m_good >= vthr)
                            m_state = AM_LOCKED;
                    end
                    else if (slot || lane >= 0)
                        m_state = AM_UNLOCKED;   // wrong lane, miss or out of slot
                AM_LOCKED:
                    if (slot && hit)
                    begin
                        m_bad = 0;
                        e.sol = 1'b1;
                    end
                    else if (slot)
                    begin
                        m_bad++;
                        m_err++;
                        if (m_bad >= ithr)
                        begin
                            e.resync = 1'b1;
                            m_state  = AM_UNLOCKED;
                        end
                    end
                default:
                    m_state = AM_UNLOCKED;
            endcase
        end
        e.lock = (m_state == AM_LOCKED);
        e.lane = m_lane;
        e.err  = m_err;
        exp_q.push_back(e);
    endfunction

    task automatic drive_cycle(input logic vld, input logic [NB_CODED_BLOCK-1:0] blk);
        @(posedge tb_clock);
        #0.5;
        enable  = 1'b1;
        valid   = vld;
        data_in = blk;
        if (vld)
            model_accept(blk);
    endtask

    task automatic send_block(input logic [NB_CODED_BLOCK-1:0] blk);
        int gaps;
        gaps = 0;
        while (gaps < 3 && rand_range(0, 3) == 0)
        begin
            drive_cycle(1'b0, random_block());   // bubble
            gaps++;
        end
        drive_cycle(1'b1, blk);
    endtask

    // marker of lane (or data when lane is -1) followed by data blocks
    task automatic send_span(input int lane, input int len);
        if (lane >= 0)
            send_block(make_marker(lane));
        else
            send_block(random_block());
        repeat (len - 1)
            send_block(random_block());
    endtask

    task automatic wait_drain();
        int cycles;
        cycles = 0;
        @(posedge tb_clock);
        #0.5;
        valid = 1'b0;
        while (exp_q.size() != 0 && cycles < 200)
        begin
            @(posedge tb_clock);
            #0.5;
            cycles++;
        end
        if (exp_q.size() != 0)
        begin
            timeouts++;
            $display("timeout: %0d blocks never came out of the DUT", exp_q.size());
            exp_q.delete();
        end
    endtask

    task automatic hold_enable(input int cycles);
        repeat (cycles)
        begin
            @(posedge tb_clock);
            #0.5;
            enable  = 1'b0;
            valid   = (rand_range(0, 1) == 1);   // must be ignored
            data_in = random_block();
        end
        @(negedge tb_clock);
        check_value("o_am_lock during hold", am_lock, m_state == AM_LOCKED);
        check_value("o_valid during hold", out_valid, 1'b0);
    endtask

    task automatic drop_block_lock(input int lane, input int periods);
        wait_drain();
        @(posedge tb_clock);
        #0.5;
        block_lock = 1'b0;
        m_state    = AM_UNLOCKED;
        @(posedge tb_clock);
        @(negedge tb_clock);
        check_value("o_am_lock after block lock loss", am_lock, 1'b0);
        repeat (periods)
            send_span(lane, N_BLOCKS);   // markers ignored without block lock
        wait_drain();
        block_lock = 1'b1;
    endtask

    task automatic set_thresholds(input int v, input int inv);
        wait_drain();
        vthr        = v;
        ithr        = inv;
        valid_thr   = NB_VAL_AM'(v);
        invalid_thr = NB_INV_AM'(inv);
    endtask

    // outputs are compared at the falling edge
    always @(negedge tb_clock)
    begin
        if (!tb_reset)
        begin
            if (out_valid && exp_q.size() == 0)
            begin
                errors++;
                $display("the DUT put out a block at %0t ns that was never sent", $time);
            end
            else if (out_valid)
            begin
                head = exp_q.pop_front();
                check_value("output cycle of block", cycle_count, head.due);
                check_value("o_data", out_data, head.data);
                check_value("o_am_lock", am_lock, head.lock);
                check_value("o_resync", resync, head.resync);
                check_value("o_start_of_lane", start_of_lane, head.sol);
                check_value("o_error_counter", error_counter, head.err);
                if (head.lock)
                    check_value("o_lane_id", lane_id, head.lane);
                lock_seen   += am_lock;
                resync_seen += resync;
                sol_seen    += start_of_lane;
            end
            else
            begin
                check_value("o_resync without block", resync, 1'b0);
                check_value("o_start_of_lane without block", start_of_lane, 1'b0);
            end
        end
    end

    initial
    begin
        int lane;
        int other;
        int pick;
        int sva_fails;
        seed        = 86808;
        errors      = 0;
        timeouts    = 0;
        lock_seen   = 0;
        resync_seen = 0;
        sol_seen    = 0;
        cycle_count = 0;
        tb_clock    = 1'b0;
        tb_reset    = 1'b1;
        enable      = 1'b1;
        valid       = 1'b0;
        block_lock  = 1'b1;
        data_in     = '0;
        m_state     = AM_UNLOCKED;
        m_lane      = '0;
        m_good      = 0;
        m_bad       = 0;
        m_since     = 0;
        m_err       = '0;
        vthr        = rand_range(2, 5);
        ithr        = rand_range(2, 4);
        valid_thr   = NB_VAL_AM'(vthr);
        invalid_thr = NB_INV_AM'(ithr);

        repeat (4) @(posedge tb_clock);
        #0.5;
        tb_reset = 1'b0;
        @(negedge tb_clock);
        check_value("o_valid after reset", out_valid, 1'b0);
        check_value("o_am_lock after reset", am_lock, 1'b0);
        check_value("o_resync after reset", resync, 1'b0);
        check_value("o_start_of_lane after reset", start_of_lane, 1'b0);
        check_value("o_lane_id after reset", lane_id, '0);
        check_value("o_error_counter after reset", error_counter, '0);

        repeat (25)
            send_block(random_block());

        // acquire on one lane with random misses and then a sure loss
        lane = rand_range(0, N_ALIGNER - 1);
        repeat (vthr + 2)
            send_span(lane, N_BLOCKS);
        repeat (12)
            send_span(rand_range(0, 1) ? lane : -1, N_BLOCKS);
        repeat (vthr + 1)
            send_span(lane, N_BLOCKS);
        repeat (ithr)
            send_span(-1, N_BLOCKS);

        // acquisition broken by an early marker and then by another lane
        other = (lane + rand_range(1, N_ALIGNER - 1)) % N_ALIGNER;
        send_span(lane, rand_range(2, N_BLOCKS - 1));
        send_span(lane, N_BLOCKS);
        send_span(-1, N_BLOCKS);
        send_span(lane, N_BLOCKS);
        send_span(other, N_BLOCKS);
        send_span(-1, N_BLOCKS);

        // enable low mid period and at a period boundary
        repeat (vthr + 1)
            send_span(other, N_BLOCKS);
        send_span(other, N_BLOCKS / 2);
        hold_enable(6);
        send_span(-1, N_BLOCKS - N_BLOCKS / 2);
        repeat (2)
            send_span(other, N_BLOCKS);
        hold_enable(5);
        repeat (2)
            send_span(other, N_BLOCKS);

        drop_block_lock(other, 2);
        repeat (vthr + 1)
            send_span(lane, N_BLOCKS);

        // random mix with new thresholds
        set_thresholds(rand_range(1, 3), rand_range(1, 3));
        repeat (60)
        begin
            pick = rand_range(0, 9);
            if (pick < 6)
                send_span(lane, N_BLOCKS);
            else if (pick < 8)
                send_span(-1, N_BLOCKS);
            else if (pick == 8)
                send_span(rand_range(0, N_ALIGNER - 1), N_BLOCKS);
            else
                send_span(lane, rand_range(1, N_BLOCKS + 2));
        end

        wait_drain();
        if (lock_seen == 0 || resync_seen == 0 || sol_seen == 0)
        begin
            errors++;
            $display("lock, resync or start of lane never showed up at the DUT outputs");
        end
        sva_fails = am_lock_top_i.am_lock_sva_i.fail_count;
        $display("errors: %0d  assertion failures: %0d  timeouts: %0d",
                 errors, sva_fails, timeouts);
        if (errors == 0 && sva_fails == 0 && timeouts == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule

// File: verilog/am_lane_output.sv
module am_lane_output
    import am_pkg::*;
(
    input  logic                        i_clock,
    input  logic                        i_reset,
    input  logic                        i_valid,
    input  logic                        i_enable,
    input  logic [NB_CODED_BLOCK-1:0]   i_data,
    input  logic                        i_am_good,
    input  logic                        i_am_bad,
    output logic                        o_valid,
    output logic [NB_CODED_BLOCK-1:0]   o_data,
    output logic                        o_start_of_lane,
    output logic [NB_ERROR_COUNTER-1:0] o_error_counter
);

    logic                        valid_q1, valid_q2;
    logic [NB_CODED_BLOCK-1:0]   data_q1, data_q2;
    logic [NB_ERROR_COUNTER-1:0] err_cnt;
    logic [NB_ERROR_COUNTER-1:0] err_next;

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            valid_q1 <= 1'b0;
            valid_q2 <= 1'b0;
        end
        else
        begin
            valid_q1 <= i_valid && i_enable;
            valid_q2 <= valid_q1;
        end
    end

    always_ff @(posedge i_clock)
    begin
        data_q1 <= i_data;
        data_q2 <= data_q1;
    end

    assign o_valid = valid_q2;
    assign o_data  = data_q2;

    // am_good arrives on the same cycle as its delayed block
    assign o_start_of_lane = i_am_good && valid_q2;

    // saturates at all ones
    assign err_next = (i_am_bad && !(&err_cnt)) ? err_cnt + 1'b1 : err_cnt;

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
            err_cnt <= '0;
        else
            err_cnt <= err_next;
    end

    assign o_error_counter = err_next;   // shows the increment with its own block

endmodule

// File: verilog/am_lock_fsm.sv
module am_lock_fsm
    import am_pkg::*;
(
    input  logic                  i_clock,
    input  logic                  i_reset,
    input  logic                  i_enable,
    input  logic                  i_block_lock,
    input  logic                  i_match_valid,
    input  logic                  i_am_match,
    input  logic [NB_LANE_ID-1:0] i_match_lane,
    input  logic                  i_am_slot,
    input  logic [NB_VAL_AM-1:0]  i_valid_am_thr,
    input  logic [NB_INV_AM-1:0]  i_invalid_am_thr,
    output logic                  o_timer_start,
    output logic                  o_timer_clear,
    output logic [NB_LANE_ID-1:0] o_lane_id,
    output logic                  o_am_lock,
    output logic                  o_resync,
    output logic                  o_am_good,
    output logic                  o_am_bad
);

    am_lock_state_t        state, state_next;
    am_lock_state_t        resume_state, resume_next;   // state to return to after hold
    logic [NB_VAL_AM-1:0]  good_cnt, good_next, good_inc;
    logic [NB_INV_AM-1:0]  bad_cnt, bad_next, bad_inc;
    logic [NB_LANE_ID-1:0] lane_id, lane_next;
    logic                  lane_hit;
    logic                  good_pulse;
    logic                  bad_pulse;
    logic                  resync_pulse;

    assign lane_hit = i_am_match && (i_match_lane == lane_id);
    assign good_inc = good_cnt + 1'b1;
    assign bad_inc  = bad_cnt + 1'b1;

    always_comb
    begin
        state_next    = state;
        resume_next   = resume_state;
        good_next     = good_cnt;
        bad_next      = bad_cnt;
        lane_next     = lane_id;
        o_timer_start = 1'b0;
        good_pulse    = 1'b0;
        bad_pulse     = 1'b0;
        resync_pulse  = 1'b0;

        if (!i_block_lock)
            state_next = AM_UNLOCKED;
        else if (!i_enable && !i_match_valid)
        begin
            // a block still in the matcher is handled before parking
            if (state != AM_HOLD)
            begin
                resume_next = state;
                state_next  = AM_HOLD;
            end
        end
        else
        begin
            case (state)
                AM_HOLD:
                    state_next = resume_state;
                AM_UNLOCKED:
                    if (i_am_match)
                    begin
                        lane_next     = i_match_lane;
                        good_next     = NB_VAL_AM'(1);
                        bad_next      = '0;
                        o_timer_start = 1'b1;
                        if (i_valid_am_thr <= NB_VAL_AM'(1))
                            state_next = AM_LOCKED;
                        else
                            state_next = AM_ACQUIRE;
                    end
                AM_ACQUIRE:
                    if (i_am_slot)
                    begin
                        if (lane_hit)
                        begin
                            good_next = good_inc;
                            if (good_inc >= i_valid_am_thr)
                                state_next = AM_LOCKED;
                        end
                        else
                            state_next = AM_UNLOCKED;
                    end
                    else if (i_am_match)
                        state_next = AM_UNLOCKED;   // marker out of slot
                AM_LOCKED:
                    if (i_am_slot)
                    begin
                        if (lane_hit)
                        begin
                            bad_next   = '0;
                            good_pulse = 1'b1;
                        end
                        else
                        begin
                            bad_next  = bad_inc;
                            bad_pulse = 1'b1;
                            if (bad_inc >= i_invalid_am_thr)
                            begin
                                resync_pulse = 1'b1;
                                state_next   = AM_UNLOCKED;
                            end
                        end
                    end
                default:
                    state_next = AM_UNLOCKED;
            endcase
        end
    end

    assign o_timer_clear = (state_next == AM_UNLOCKED);
    assign o_lane_id     = lane_id;

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            state        <= AM_UNLOCKED;
            resume_state <= AM_UNLOCKED;
            good_cnt     <= '0;
            bad_cnt      <= '0;
            lane_id      <= '0;
            o_am_lock    <= 1'b0;
            o_resync     <= 1'b0;
            o_am_good    <= 1'b0;
            o_am_bad     <= 1'b0;
        end
        else
        begin
            state        <= state_next;
            resume_state <= resume_next;
            good_cnt     <= good_next;
            bad_cnt      <= bad_next;
            lane_id      <= lane_next;
            // lock stays visible while parked in hold
            o_am_lock    <= (state_next == AM_LOCKED)
                         || (state_next == AM_HOLD && resume_next == AM_LOCKED);
            o_resync     <= resync_pulse;
            o_am_good    <= good_pulse;
            o_am_bad     <= bad_pulse;
        end
    end

endmodule

// File: verilog/am_lock_top.sv
module am_lock_top
    import am_pkg::*;
(
    input  logic                        i_clock,
    input  logic                        i_reset,
    input  logic                        i_enable,
    input  logic                        i_valid,
    input  logic                        i_block_lock,
    input  logic [NB_CODED_BLOCK-1:0]   i_data,
    input  logic [NB_VAL_AM-1:0]        i_valid_am_thr,
    input  logic [NB_INV_AM-1:0]        i_invalid_am_thr,
    output logic                        o_valid,
    output logic [NB_CODED_BLOCK-1:0]   o_data,
    output logic [NB_LANE_ID-1:0]       o_lane_id,
    output logic                        o_am_lock,
    output logic                        o_resync,
    output logic                        o_start_of_lane,
    output logic [NB_ERROR_COUNTER-1:0] o_error_counter
);

    logic                  match_valid;
    logic                  am_match;
    logic [NB_LANE_ID-1:0] match_lane;
    logic                  am_slot;
    logic                  timer_start;
    logic                  timer_clear;
    logic                  am_good;
    logic                  am_bad;

    am_marker_match am_marker_match_i (
        .i_clock       (i_clock),
        .i_reset       (i_reset),
        .i_valid       (i_valid),
        .i_enable      (i_enable),
        .i_data        (i_data),
        .o_match_valid (match_valid),
        .o_am_match    (am_match),
        .o_match_lane  (match_lane)
    );

    am_period_timer am_period_timer_i (
        .i_clock   (i_clock),
        .i_reset   (i_reset),
        .i_step    (match_valid),
        .i_start   (timer_start),
        .i_clear   (timer_clear),
        .o_am_slot (am_slot)
    );

    am_lock_fsm am_lock_fsm_i (
        .i_clock          (i_clock),
        .i_reset          (i_reset),
        .i_enable         (i_enable),
        .i_block_lock     (i_block_lock),
        .i_match_valid    (match_valid),
        .i_am_match       (am_match),
        .i_match_lane     (match_lane),
        .i_am_slot        (am_slot),
        .i_valid_am_thr   (i_valid_am_thr),
        .i_invalid_am_thr (i_invalid_am_thr),
        .o_timer_start    (timer_start),
        .o_timer_clear    (timer_clear),
        .o_lane_id        (o_lane_id),
        .o_am_lock        (o_am_lock),
        .o_resync         (o_resync),
        .o_am_good        (am_good),
        .o_am_bad         (am_bad)
    );

    // two cycle data delay lines up with the fsm outputs
    am_lane_output am_lane_output_i (
        .i_clock         (i_clock),
        .i_reset         (i_reset),
        .i_valid         (i_valid),
        .i_enable        (i_enable),
        .i_data          (i_data),
        .i_am_good       (am_good),
        .i_am_bad        (am_bad),
        .o_valid         (o_valid),
        .o_data          (o_data),
        .o_start_of_lane (o_start_of_lane),
        .o_error_counter (o_error_counter)
    );

endmodule

// File: verilog/am_marker_match.sv
module am_marker_match
    import am_pkg::*;
(
    input  logic                      i_clock,
    input  logic                      i_reset,
    input  logic                      i_valid,
    input  logic                      i_enable,
    input  logic [NB_CODED_BLOCK-1:0] i_data,
    output logic                      o_match_valid,
    output logic                      o_am_match,
    output logic [NB_LANE_ID-1:0]     o_match_lane
);

    logic                  accept;
    logic                  header_ok;
    logic [N_ALIGNER-1:0]  hit;       // one bit per table entry
    logic [NB_LANE_ID-1:0] hit_lane;

    assign accept    = i_valid && i_enable;
    assign header_ok = (i_data[65:64] == AM_SYNC_HEADER);

    // M0..M2 sit in [63:40], their complements in [31:8]
    // BIP3 [39:32] and BIP7 [7:0] are not looked at
    always_comb
    begin
        for (int k = 0; k < N_ALIGNER; k++)
        begin
            hit[k] = header_ok
                  && (i_data[63:40] == AM_TABLE[k])
                  && (i_data[31:8] == ~AM_TABLE[k]);
        end
    end

    // table entries are distinct, so at most one bit is set
    always_comb
    begin
        hit_lane = '0;
        for (int k = 0; k < N_ALIGNER; k++)
        begin
            if (hit[k])
                hit_lane = NB_LANE_ID'(k);
        end
    end

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            o_match_valid <= 1'b0;
            o_am_match    <= 1'b0;
        end
        else
        begin
            o_match_valid <= accept;
            o_am_match    <= accept && (|hit);
        end
    end

    always_ff @(posedge i_clock)
    begin
        if (accept)
            o_match_lane <= hit_lane;   // only read together with o_am_match
    end

endmodule

// File: verilog/am_period_timer.sv
module am_period_timer
    import am_pkg::*;
(
    input  logic i_clock,
    input  logic i_reset,
    input  logic i_step,     // one accepted block
    input  logic i_start,    // first marker seen, counts as slot zero
    input  logic i_clear,
    output logic o_am_slot
);

    logic [NB_BLOCK_CNT-1:0] blk_cnt;   // accepted blocks since last slot
    logic                    running;

    // slot lands on the N_BLOCKS-th step after the previous one
    assign o_am_slot = running && i_step
                    && (blk_cnt == NB_BLOCK_CNT'(N_BLOCKS - 1));

    always_ff @(posedge i_clock)
    begin
        if (i_reset || i_clear)
        begin
            running <= 1'b0;
            blk_cnt <= '0;
        end
        else if (i_start)
        begin
            running <= 1'b1;
            blk_cnt <= '0;
        end
        else if (running && i_step)
        begin
            if (o_am_slot)
                blk_cnt <= '0;   // wrap, next period begins
            else
                blk_cnt <= blk_cnt + 1'b1;
        end
    end

endmodule

// File: verilog/am_pkg.sv
package am_pkg;

    // coded block and lane marker geometry
    localparam int NB_CODED_BLOCK = 66;
    localparam int N_ALIGNER      = 20;
    localparam int NB_LANE_ID     = $clog2(N_ALIGNER);

    // marker period in accepted blocks, kept short for simulation
    localparam int N_BLOCKS       = 10;
    localparam int NB_BLOCK_CNT   = $clog2(N_BLOCKS + 1);

    // lock thresholds
    localparam int MAX_VAL_AM     = 20;
    localparam int NB_VAL_AM      = $clog2(MAX_VAL_AM + 1);
    localparam int MAX_INV_AM     = 8;
    localparam int NB_INV_AM      = $clog2(MAX_INV_AM + 1);

    localparam int NB_ERROR_COUNTER = 64;

    localparam logic [1:0] AM_SYNC_HEADER = 2'b10;   // control block header

    // M0 M1 M2 per physical lane
    // bytes 5..7 of a marker carry the complement of these
    localparam logic [23:0] AM_TABLE [N_ALIGNER] = '{
        24'hC1_68_21,   // lane 0
        24'h9D_71_8E,
        24'h59_4B_E8,
        24'h4D_95_7B,
        24'hF5_07_09,   // lane 4
        24'hDD_14_C2,
        24'h9A_4A_26,
        24'h7B_45_66,
        24'hA0_24_76,
        24'h68_C9_FB,
        24'hFD_6C_99,   // lane 10
        24'hB9_91_55,
        24'h5C_B9_B2,
        24'h1A_F8_BD,
        24'h83_C7_CA,
        24'h35_36_CD,
        24'hC4_31_4C,
        24'hAD_D6_B7,
        24'h5F_66_2A,
        24'hC0_F0_E5    // lane 19
    };

    // lock state machine
    typedef enum logic [1:0] {
        AM_UNLOCKED,    // searching for a first marker
        AM_ACQUIRE,     // counting good markers
        AM_LOCKED,
        AM_HOLD         // parked while enable is low
    } am_lock_state_t;

endpackage
